/* filelist.f */
+incdir+hw
hw/tagbuf_pkg.sv
hw/capture_ctrl.sv
hw/banked_buffer.sv
hw/readout_ctrl.sv
hw/timetag_buffer.sv
sim/timetag_buffer_sva.sv
sim/timetag_buffer_tb.sv

/* hw/banked_buffer.sv */
`timescale 1ns/1ps
`include "tagbuf_cfg.svh"

module banked_buffer
  import tagbuf_pkg::*;
#(
  parameter  int DEPTH  = `TAGBUF_SAMPLE_DEPTH,
  localparam int CH     = `TAGBUF_CHANNELS,
  localparam int CH_W   = $clog2(CH),
  localparam int ADDR_W = $clog2(2 * DEPTH),
  localparam int CNT_W  = ADDR_W + 1
) (
  input  logic                         ps_clk,
  input  logic                         rst_i,
  input  logic                         capture_en_i,
  input  logic                         bank_mode_i,
  input  logic                         clear_i,
  input  logic         [CH-1:0]        wr_valid_i,
  input  tagbuf_word_u [CH-1:0]        wr_data_i,
  input  logic                         rd_en_i,
  input  logic         [CH_W-1:0]      rd_chan_i,
  input  logic         [ADDR_W-1:0]    rd_addr_i,
  output tagbuf_word_u                 rd_data_o,
  output logic  [CH-1:0][CNT_W-1:0]    depth_o,
  output logic                         full_o
);

  localparam int BANK_AW = $clog2(DEPTH);
  localparam int LAT     = `TAGBUF_READ_LATENCY;

  tagbuf_word_u mem [CH][DEPTH];
  tagbuf_word_u rd_pipe [LAT];

  logic [CH-1:0][CNT_W-1:0]   cnt_q;
  logic [CH-1:0]              active;
  logic [CH-1:0]              accept;
  logic [CNT_W-1:0]           capacity;

  logic [CH-1:0]              bank_we;
  logic [CH-1:0][BANK_AW-1:0] bank_waddr;
  tagbuf_word_u [CH-1:0]      bank_wdata;

  logic [CH_W-1:0]            rd_bank;
  logic [BANK_AW-1:0]         rd_bank_addr;

  // joined mode keeps only channel 0, with both banks behind it
  assign capacity = bank_mode_i ? CNT_W'(2 * DEPTH) : CNT_W'(DEPTH);

  always_comb begin
    full_o = 1'b0;
    for (int c = 0; c < CH; c++) begin
      active[c] = !bank_mode_i || (c == 0);
      if (active[c] && (cnt_q[c] == capacity)) begin
        full_o = 1'b1;
      end
    end
  end

  // any full logical buffer stops every channel
  always_comb begin
    for (int c = 0; c < CH; c++) begin
      accept[c] = capture_en_i && active[c] && wr_valid_i[c] && !full_o;
    end
  end

  always_comb begin
    for (int b = 0; b < CH; b++) begin
      if (bank_mode_i) begin
        // bank picked by the bit just above the bank address
        bank_we[b]    = accept[0] && (cnt_q[0][BANK_AW] == 1'(b));
        bank_waddr[b] = cnt_q[0][BANK_AW-1:0];
        bank_wdata[b] = wr_data_i[0];
      end else begin
        bank_we[b]    = accept[b];
        bank_waddr[b] = cnt_q[b][BANK_AW-1:0];
        bank_wdata[b] = wr_data_i[b];
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (rst_i || clear_i) begin
      cnt_q <= '0;
    end else begin
      for (int c = 0; c < CH; c++) begin
        if (accept[c]) begin
          cnt_q[c] <= cnt_q[c] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    for (int b = 0; b < CH; b++) begin
      if (bank_we[b]) begin
        mem[b][bank_waddr[b]] <= bank_wdata[b];
      end
    end
  end

  // logical address to bank and bank address
  always_comb begin
    if (bank_mode_i) begin
      rd_bank = CH_W'(rd_addr_i[BANK_AW]);
    end else begin
      rd_bank = rd_chan_i;
    end
    rd_bank_addr = rd_addr_i[BANK_AW-1:0];
  end

  // memory read register, then the rest of the latency
  always_ff @(posedge ps_clk) begin
    if (rd_en_i) begin
      rd_pipe[0] <= mem[rd_bank][rd_bank_addr];
    end
    for (int i = 1; i < LAT; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data_o = rd_pipe[LAT-1];
  assign depth_o   = cnt_q;

endmodule

/* hw/capture_ctrl.sv */
`timescale 1ns/1ps

module capture_ctrl
  import tagbuf_pkg::*;
(
  input  logic ps_clk,
  input  logic rst_i,
  input  logic cmd_valid_i,
  input  logic cmd_arm_i,
  input  logic cmd_start_i,
  input  logic cmd_stop_i,
  input  logic trigger_i,
  input  logic banking_mode_i,
  input  logic capture_reset_i,
  input  logic sample_full_i,
  input  logic tstamp_full_i,
  output logic capture_en_o,
  output logic bank_mode_o,
  output logic buf_clear_o,
  output logic capture_done_o
);

  capture_state_e state_q;
  logic           bank_mode_q;
  logic           arm_cmd;
  logic           start_cmd;
  logic           stop_cmd;
  logic           arm_ok;
  logic           any_full;

  // flags only count while the command strobe is up
  assign arm_cmd   = cmd_valid_i && cmd_arm_i;
  assign start_cmd = cmd_valid_i && cmd_start_i;
  assign stop_cmd  = cmd_valid_i && cmd_stop_i;
  assign any_full  = sample_full_i || tstamp_full_i;

  // no re-arm while a capture is running
  assign arm_ok = arm_cmd && (state_q != CAP_CAPTURING) && !capture_reset_i;

  always_ff @(posedge ps_clk) begin
    if (rst_i) begin
      state_q     <= CAP_IDLE;
      bank_mode_q <= 1'b0;
    end else if (capture_reset_i) begin
      state_q <= CAP_IDLE;
    end else if (arm_ok) begin
      bank_mode_q <= banking_mode_i;
      // arm with start skips the wait for a trigger
      state_q <= start_cmd ? CAP_CAPTURING : CAP_ARMED;
    end else begin
      case (state_q)
        CAP_ARMED: begin
          if (trigger_i) begin
            state_q <= CAP_CAPTURING;
          end
        end
        CAP_CAPTURING: begin
          if (stop_cmd || any_full) begin
            state_q <= CAP_DONE;
          end
        end
        default: begin
          state_q <= state_q;
        end
      endcase
    end
  end

  assign capture_en_o   = (state_q == CAP_CAPTURING);
  assign capture_done_o = (state_q == CAP_DONE);
  assign bank_mode_o    = bank_mode_q;

  // clear lands on the same edge as the new state, before any write
  assign buf_clear_o = capture_reset_i || arm_ok;

endmodule

/* hw/readout_ctrl.sv */
`timescale 1ns/1ps
`include "tagbuf_cfg.svh"

module readout_ctrl
  import tagbuf_pkg::*;
#(
  localparam int CH       = `TAGBUF_CHANNELS,
  localparam int CH_W     = $clog2(CH),
  localparam int TS_CNT_W = $clog2(2 * `TAGBUF_TSTAMP_DEPTH) + 1,
  localparam int SP_CNT_W = $clog2(2 * `TAGBUF_SAMPLE_DEPTH) + 1,
  localparam int CNT_W    = (TS_CNT_W > SP_CNT_W) ? TS_CNT_W : SP_CNT_W,
  localparam int ADDR_W   = CNT_W - 1
) (
  input  logic                         ps_clk,
  input  logic                         rst_i,
  input  logic                         start_i,
  input  logic                         reset_i,
  input  logic                         capture_done_i,
  input  logic [CH-1:0][TS_CNT_W-1:0]  tstamp_depth_i,
  input  logic [CH-1:0][SP_CNT_W-1:0]  sample_depth_i,
  input  tagbuf_word_u                 tstamp_rd_data_i,
  input  tagbuf_word_u                 sample_rd_data_i,
  output logic                         tstamp_rd_en_o,
  output logic                         sample_rd_en_o,
  output logic [CH_W-1:0]              rd_chan_o,
  output logic [ADDR_W-1:0]            rd_addr_o,
  output logic [`TAGBUF_WORD_W-1:0]    out_data_o,
  output logic                         out_valid_o,
  output logic                         out_last_o
);

  localparam int LAT   = `TAGBUF_READ_LATENCY;
  localparam int NPOS  = 2 * CH;
  localparam int POS_W = $clog2(NPOS);

  // stream position: timestamp channels first, then sample channels
  logic                       busy_q;
  logic [POS_W-1:0]           pos_q;
  logic [ADDR_W-1:0]          addr_q;

  logic [NPOS-1:0][CNT_W-1:0] pos_depth;
  logic [NPOS-1:0]            pos_nz;
  logic                       first_found;
  logic [POS_W-1:0]           first_pos;
  logic                       next_found;
  logic [POS_W-1:0]           next_pos;
  logic                       pos_end;

  logic [LAT-1:0]             valid_pipe;
  logic [LAT-1:0]             last_pipe;
  logic [LAT-1:0]             src_pipe;

  // lowest nonempty position at or above from, found flag on top
  function automatic logic [POS_W:0] find_from(
    input logic [NPOS-1:0] nz,
    input int              from
  );
    logic [POS_W:0] res;
    res = '0;
    for (int p = NPOS - 1; p >= 0; p--) begin
      if (nz[p] && (p >= from)) begin
        res = {1'b1, POS_W'(p)};
      end
    end
    return res;
  endfunction

  always_comb begin
    for (int c = 0; c < CH; c++) begin
      pos_depth[c]      = CNT_W'(tstamp_depth_i[c]);
      pos_depth[c + CH] = CNT_W'(sample_depth_i[c]);
    end
    for (int p = 0; p < NPOS; p++) begin
      pos_nz[p] = (pos_depth[p] != '0);
    end
    {first_found, first_pos} = find_from(pos_nz, 0);
    {next_found, next_pos}   = find_from(pos_nz, int'(pos_q) + 1);
    pos_end = ((CNT_W'(addr_q) + 1'b1) == pos_depth[pos_q]);
  end

  always_ff @(posedge ps_clk) begin
    if (rst_i || reset_i) begin
      busy_q <= 1'b0;
      pos_q  <= '0;
      addr_q <= '0;
    end else if (!busy_q && start_i && capture_done_i) begin
      // nothing captured means nothing sent
      busy_q <= first_found;
      pos_q  <= first_pos;
      addr_q <= '0;
    end else if (busy_q) begin
      if (pos_end) begin
        busy_q <= next_found;
        pos_q  <= next_pos;
        addr_q <= '0;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // one stage per cycle of buffer read latency
  always_ff @(posedge ps_clk) begin
    if (rst_i || reset_i) begin
      valid_pipe <= '0;
      last_pipe  <= '0;
    end else begin
      valid_pipe[0] <= busy_q;
      last_pipe[0]  <= busy_q && pos_end && !next_found;
      for (int i = 1; i < LAT; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
        last_pipe[i]  <= last_pipe[i-1];
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    src_pipe[0] <= (pos_q >= CH);
    for (int i = 1; i < LAT; i++) begin
      src_pipe[i] <= src_pipe[i-1];
    end
  end

  always_comb begin
    if (pos_q >= CH) begin
      rd_chan_o = CH_W'(pos_q - CH);
    end else begin
      rd_chan_o = CH_W'(pos_q);
    end
  end

  assign tstamp_rd_en_o = busy_q && (pos_q < CH);
  assign sample_rd_en_o = busy_q && (pos_q >= CH);
  assign rd_addr_o      = addr_q;

  assign out_data_o  = src_pipe[LAT-1] ? sample_rd_data_i : tstamp_rd_data_i;
  assign out_valid_o = valid_pipe[LAT-1];
  assign out_last_o  = last_pipe[LAT-1];

endmodule

/* hw/tagbuf_cfg.svh */
`ifndef TAGBUF_CFG_SVH
`define TAGBUF_CFG_SVH

// input channels, each with its own sample and timestamp bank
`define TAGBUF_CHANNELS 2

// stored and streamed word
`define TAGBUF_WORD_W 32

// one ADC sample, two of them per stored word
`define TAGBUF_SAMPLE_W 16

// words per bank
`define TAGBUF_SAMPLE_DEPTH 64
`define TAGBUF_TSTAMP_DEPTH 32

// cycles from read strobe to data at the buffer output
`define TAGBUF_READ_LATENCY 2

`endif

/* hw/tagbuf_pkg.sv */
`include "tagbuf_cfg.svh"

package tagbuf_pkg;

  // capture controller states
  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_ARMED,
    CAP_CAPTURING,
    CAP_DONE
  } capture_state_e;

  // one stored word, seen as a timestamp or as a sample pair
  // older sample sits in the low half
  typedef union packed {
    logic [`TAGBUF_WORD_W-1:0] tstamp;
    struct packed {
      logic [`TAGBUF_SAMPLE_W-1:0] newer;
      logic [`TAGBUF_SAMPLE_W-1:0] older;
    } pair;
  } tagbuf_word_u;

endpackage

/* hw/timetag_buffer.sv */
`timescale 1ns/1ps
`include "tagbuf_cfg.svh"

module timetag_buffer
  import tagbuf_pkg::*;
#(
  localparam int CH       = `TAGBUF_CHANNELS,
  localparam int TS_CNT_W = $clog2(2 * `TAGBUF_TSTAMP_DEPTH) + 1,
  localparam int SP_CNT_W = $clog2(2 * `TAGBUF_SAMPLE_DEPTH) + 1
) (
  input  logic                                    ps_clk,
  input  logic                                    rst_i,
  input  logic [CH-1:0]                           sample_valid_i,
  input  logic [CH-1:0][1:0][`TAGBUF_SAMPLE_W-1:0] sample_data_i,
  input  logic [CH-1:0]                           tstamp_valid_i,
  input  logic [CH-1:0][`TAGBUF_WORD_W-1:0]       tstamp_data_i,
  input  logic                                    trigger_i,
  input  logic                                    cmd_valid_i,
  input  logic                                    cmd_arm_i,
  input  logic                                    cmd_start_i,
  input  logic                                    cmd_stop_i,
  input  logic                                    banking_mode_i,
  input  logic                                    capture_reset_i,
  input  logic                                    readout_start_i,
  input  logic                                    readout_reset_i,
  output logic [`TAGBUF_WORD_W-1:0]               out_data_o,
  output logic                                    out_valid_o,
  output logic                                    out_last_o,
  output logic [CH-1:0][SP_CNT_W-1:0]             sample_depth_o,
  output logic [CH-1:0][TS_CNT_W-1:0]             tstamp_depth_o,
  output logic                                    capture_done_o
);

  localparam int CH_W      = $clog2(CH);
  localparam int TS_ADDR_W = TS_CNT_W - 1;
  localparam int SP_ADDR_W = SP_CNT_W - 1;

  logic                  capture_en;
  logic                  bank_mode;
  logic                  buf_clear;
  logic                  sample_full;
  logic                  tstamp_full;
  tagbuf_word_u [CH-1:0] sample_word;
  tagbuf_word_u [CH-1:0] tstamp_word;
  logic                  tstamp_rd_en;
  logic                  sample_rd_en;
  logic [CH_W-1:0]       rd_chan;
  logic [SP_ADDR_W-1:0]  rd_addr;
  tagbuf_word_u          tstamp_rd_data;
  tagbuf_word_u          sample_rd_data;

  // sample pairs go in through the pair view, timestamps whole
  always_comb begin
    for (int c = 0; c < CH; c++) begin
      sample_word[c].pair.older = sample_data_i[c][0];
      sample_word[c].pair.newer = sample_data_i[c][1];
      tstamp_word[c].tstamp     = tstamp_data_i[c];
    end
  end

  capture_ctrl u_capture_ctrl (
    .ps_clk          (ps_clk),
    .rst_i           (rst_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_arm_i       (cmd_arm_i),
    .cmd_start_i     (cmd_start_i),
    .cmd_stop_i      (cmd_stop_i),
    .trigger_i       (trigger_i),
    .banking_mode_i  (banking_mode_i),
    .capture_reset_i (capture_reset_i),
    .sample_full_i   (sample_full),
    .tstamp_full_i   (tstamp_full),
    .capture_en_o    (capture_en),
    .bank_mode_o     (bank_mode),
    .buf_clear_o     (buf_clear),
    .capture_done_o  (capture_done_o)
  );

  banked_buffer #(
    .DEPTH (`TAGBUF_SAMPLE_DEPTH)
  ) sample_buf (
    .ps_clk       (ps_clk),
    .rst_i        (rst_i),
    .capture_en_i (capture_en),
    .bank_mode_i  (bank_mode),
    .clear_i      (buf_clear),
    .wr_valid_i   (sample_valid_i),
    .wr_data_i    (sample_word),
    .rd_en_i      (sample_rd_en),
    .rd_chan_i    (rd_chan),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (sample_rd_data),
    .depth_o      (sample_depth_o),
    .full_o       (sample_full)
  );

  // timestamp banks are shallower, so only the low address bits apply
  banked_buffer #(
    .DEPTH (`TAGBUF_TSTAMP_DEPTH)
  ) tstamp_buf (
    .ps_clk       (ps_clk),
    .rst_i        (rst_i),
    .capture_en_i (capture_en),
    .bank_mode_i  (bank_mode),
    .clear_i      (buf_clear),
    .wr_valid_i   (tstamp_valid_i),
    .wr_data_i    (tstamp_word),
    .rd_en_i      (tstamp_rd_en),
    .rd_chan_i    (rd_chan),
    .rd_addr_i    (rd_addr[TS_ADDR_W-1:0]),
    .rd_data_o    (tstamp_rd_data),
    .depth_o      (tstamp_depth_o),
    .full_o       (tstamp_full)
  );

  readout_ctrl u_readout_ctrl (
    .ps_clk           (ps_clk),
    .rst_i            (rst_i),
    .start_i          (readout_start_i),
    .reset_i          (readout_reset_i),
    .capture_done_i   (capture_done_o),
    .tstamp_depth_i   (tstamp_depth_o),
    .sample_depth_i   (sample_depth_o),
    .tstamp_rd_data_i (tstamp_rd_data),
    .sample_rd_data_i (sample_rd_data),
    .tstamp_rd_en_o   (tstamp_rd_en),
    .sample_rd_en_o   (sample_rd_en),
    .rd_chan_o        (rd_chan),
    .rd_addr_o        (rd_addr),
    .out_data_o       (out_data_o),
    .out_valid_o      (out_valid_o),
    .out_last_o       (out_last_o)
  );

endmodule

/* sim/timetag_buffer_sva.sv */
`timescale 1ns/1ps

module timetag_buffer_sva #(
  parameter int SP_W = 16,
  parameter int TS_W = 14
) (
  input logic            ps_clk,
  input logic            rst_i,
  input logic            capture_en_i,
  input logic            buf_clear_i,
  input logic            capture_done_i,
  input logic            out_valid_i,
  input logic            out_last_i,
  input logic [SP_W-1:0] sample_depth_i,
  input logic [TS_W-1:0] tstamp_depth_i
);

  int err_count = 0;

  // last marks a word that is actually on the stream
  last_has_valid: assert property (@(posedge ps_clk) disable iff (rst_i)
    out_last_i |-> out_valid_i)
  else begin
    $error("out_last_o high without out_valid_o");
    err_count++;
  end

  quiet_after_reset: assert property (@(posedge ps_clk)
    rst_i |=> (!out_valid_i && !capture_en_i))
  else begin
    $error("out_valid_o or capture_en high after reset");
    err_count++;
  end

  // done holds the depths until a clear
  done_no_write: assert property (@(posedge ps_clk) disable iff (rst_i)
    (capture_done_i && !buf_clear_i) |=> ($stable(sample_depth_i) && $stable(tstamp_depth_i)))
  else begin
    $error("buffer depth changed in the done state");
    err_count++;
  end

endmodule

bind timetag_buffer timetag_buffer_sva sva_chk (
  .ps_clk         (ps_clk),
  .rst_i          (rst_i),
  .capture_en_i   (capture_en),
  .buf_clear_i    (buf_clear),
  .capture_done_i (capture_done_o),
  .out_valid_i    (out_valid_o),
  .out_last_i     (out_last_o),
  .sample_depth_i (sample_depth_o),
  .tstamp_depth_i (tstamp_depth_o)
);

/* sim/timetag_buffer_tb.sv */
`timescale 1ns/1ps
`include "tagbuf_cfg.svh"

module timetag_buffer_tb
  import tagbuf_pkg::*;
();

  localparam int CH       = `TAGBUF_CHANNELS;
  localparam int LAT      = `TAGBUF_READ_LATENCY;
  localparam int SD       = `TAGBUF_SAMPLE_DEPTH;
  localparam int TD       = `TAGBUF_TSTAMP_DEPTH;
  localparam int SP_CNT_W = $clog2(2 * SD) + 1;
  localparam int TS_CNT_W = $clog2(2 * TD) + 1;
  // capture plus readout per configuration, bounded by both buffers' capacity
  localparam int N_CONFIGS   = 10;
  localparam int CYCLE_LIMIT = N_CONFIGS * 2 * CH * (SD + TD) + 500;

  logic                                     ps_clk;
  logic                                     rst_i;
  logic [CH-1:0]                            sample_valid_i;
  logic [CH-1:0][1:0][`TAGBUF_SAMPLE_W-1:0] sample_data_i;
  logic [CH-1:0]                            tstamp_valid_i;
  logic [CH-1:0][`TAGBUF_WORD_W-1:0]        tstamp_data_i;
  logic                                     trigger_i;
  logic                                     cmd_valid_i;
  logic                                     cmd_arm_i;
  logic                                     cmd_start_i;
  logic                                     cmd_stop_i;
  logic                                     banking_mode_i;
  logic                                     capture_reset_i;
  logic                                     readout_start_i;
  logic                                     readout_reset_i;
  logic [`TAGBUF_WORD_W-1:0]                out_data_o;
  logic                                     out_valid_o;
  logic                                     out_last_o;
  logic [CH-1:0][SP_CNT_W-1:0]              sample_depth_o;
  logic [CH-1:0][TS_CNT_W-1:0]              tstamp_depth_o;
  logic                                     capture_done_o;

  // reference model state
  capture_state_e m_state;
  logic           m_mode;
  int             s_cnt [CH];
  int             t_cnt [CH];
  tagbuf_word_u   s_mem [CH][2*SD];
  tagbuf_word_u   t_mem [CH][2*TD];

  logic [31:0]    seed;
  int             s_rate;
  int             t_rate;
  int             cycle_cnt = 0;

  timetag_buffer DUT (.*);

  initial begin
    ps_clk = 1'b0;
    forever #10 ps_clk = ~ps_clk;
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  initial begin : watchdog
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge ps_clk);
      cycle_cnt++;
    end
    fail_run($sformatf("timeout: run did not complete within %0d cycles", CYCLE_LIMIT));
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic int rand_range(int lo, int span);
    logic [31:0] r;
    r = next_rand();
    return lo + int'(r[31:16] % span);
  endfunction

  // capacity is one bank per channel, or both banks behind channel 0
  function automatic bit buf_full(int cnt0, int cnt1, logic mode, int depth);
    if (mode) begin
      return cnt0 == 2 * depth;
    end
    return (cnt0 == depth) || (cnt1 == depth);
  endfunction

  task automatic compare_word(tagbuf_word_u got, tagbuf_word_u exp, bit is_sample, int idx);
    if (is_sample) begin
      if (got.pair.older !== exp.pair.older) begin
        fail_run($sformatf("mismatch out_data_o.pair.older word %0d: got 0x%04h expected 0x%04h",
                           idx, got.pair.older, exp.pair.older));
      end
      if (got.pair.newer !== exp.pair.newer) begin
        fail_run($sformatf("mismatch out_data_o.pair.newer word %0d: got 0x%04h expected 0x%04h",
                           idx, got.pair.newer, exp.pair.newer));
      end
    end else if (got.tstamp !== exp.tstamp) begin
      fail_run($sformatf("mismatch out_data_o.tstamp word %0d: got 0x%08h expected 0x%08h",
                         idx, got.tstamp, exp.tstamp));
    end
  endtask

  task automatic compare_depth(string name, logic [SP_CNT_W-1:0] got, logic [SP_CNT_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // one clock edge of the reference model, from the inputs held over that edge
  task automatic model_edge();
    bit           arm_ok;
    bit           s_full;
    bit           t_full;
    tagbuf_word_u w;
    if (rst_i) begin
      m_state = CAP_IDLE;
      m_mode  = 1'b0;
      for (int c = 0; c < CH; c++) begin
        s_cnt[c] = 0;
        t_cnt[c] = 0;
      end
    end else begin
      arm_ok = cmd_valid_i && cmd_arm_i && (m_state != CAP_CAPTURING) && !capture_reset_i;
      s_full = buf_full(s_cnt[0], s_cnt[1], m_mode, SD);
      t_full = buf_full(t_cnt[0], t_cnt[1], m_mode, TD);
      if (m_state == CAP_CAPTURING) begin
        for (int c = 0; c < CH; c++) begin
          if (!m_mode || c == 0) begin
            if (!s_full && sample_valid_i[c]) begin
              w.pair.older = sample_data_i[c][0];
              w.pair.newer = sample_data_i[c][1];
              s_mem[c][s_cnt[c]] = w;
              s_cnt[c]++;
            end
            if (!t_full && tstamp_valid_i[c]) begin
              w.tstamp = tstamp_data_i[c];
              t_mem[c][t_cnt[c]] = w;
              t_cnt[c]++;
            end
          end
        end
      end
      if (capture_reset_i || arm_ok) begin
        for (int c = 0; c < CH; c++) begin
          s_cnt[c] = 0;
          t_cnt[c] = 0;
        end
      end
      if (capture_reset_i) begin
        m_state = CAP_IDLE;
      end else if (arm_ok) begin
        m_mode  = banking_mode_i;
        m_state = cmd_start_i ? CAP_CAPTURING : CAP_ARMED;
      end else if (m_state == CAP_ARMED && trigger_i) begin
        m_state = CAP_CAPTURING;
      end else if (m_state == CAP_CAPTURING &&
                   ((cmd_valid_i && cmd_stop_i) || s_full || t_full)) begin
        m_state = CAP_DONE;
      end
    end
  endtask

  task automatic check_status();
    compare_flag("capture_done_o", capture_done_o, m_state == CAP_DONE);
    for (int c = 0; c < CH; c++) begin
      compare_depth($sformatf("sample_depth_o[%0d]", c), sample_depth_o[c], s_cnt[c]);
      compare_depth($sformatf("tstamp_depth_o[%0d]", c), tstamp_depth_o[c], t_cnt[c]);
    end
    if (DUT.sva_chk.err_count != 0) begin
      fail_run("an assertion in timetag_buffer_sva failed");
    end
  endtask

  // random valids and data, stray command flags while the strobe is low
  task automatic step_cycle();
    logic [31:0] r;
    for (int c = 0; c < CH; c++) begin
      r = next_rand();
      sample_valid_i[c] = int'(r[31:28]) < s_rate;
      r = next_rand();
      tstamp_valid_i[c] = int'(r[31:28]) < t_rate;
      sample_data_i[c]  = rand_word();
      tstamp_data_i[c]  = rand_word();
    end
    if (!cmd_valid_i) begin
      r = next_rand();
      {cmd_arm_i, cmd_start_i, cmd_stop_i} = r[22:20];
    end
    @(posedge ps_clk);
    model_edge();
    #1;
    check_status();
  endtask

  task automatic send_cmd(logic arm, logic start, logic stop);
    cmd_valid_i = 1'b1;
    cmd_arm_i   = arm;
    cmd_start_i = start;
    cmd_stop_i  = stop;
    step_cycle();
    cmd_valid_i = 1'b0;
    cmd_arm_i   = 1'b0;
    cmd_start_i = 1'b0;
    cmd_stop_i  = 1'b0;
  endtask

  task automatic run_capture(logic mode, bit use_trigger, int run_len, int wait_len);
    banking_mode_i = mode;
    if (use_trigger) begin
      send_cmd(1'b1, 1'b0, 1'b0);
      repeat (wait_len) step_cycle();
      // still armed, so nothing may have been stored
      compare_depth("sample_depth_o[0]", sample_depth_o[0], '0);
      compare_depth("tstamp_depth_o[0]", tstamp_depth_o[0], '0);
      trigger_i = 1'b1;
      step_cycle();
      trigger_i = 1'b0;
    end else begin
      send_cmd(1'b1, 1'b1, 1'b0);
    end
    for (int i = 0; i < run_len && m_state == CAP_CAPTURING; i++) begin
      step_cycle();
    end
    if (m_state == CAP_CAPTURING) begin
      send_cmd(1'b0, 1'b0, 1'b1);
    end
    compare_flag("capture_done_o", capture_done_o, 1'b1);
  endtask

  // a nonzero cut_at pulses readout reset after that many words
  task automatic run_readout(int cut_at);
    tagbuf_word_u exp_q[$];
    bit           kind_q[$];
    tagbuf_word_u got;
    int           n;
    int           idx;
    bit           cut;
    for (int c = 0; c < CH; c++) begin
      for (int i = 0; i < t_cnt[c]; i++) begin
        exp_q.push_back(t_mem[c][i]);
        kind_q.push_back(1'b0);
      end
    end
    for (int c = 0; c < CH; c++) begin
      for (int i = 0; i < s_cnt[c]; i++) begin
        exp_q.push_back(s_mem[c][i]);
        kind_q.push_back(1'b1);
      end
    end
    n   = exp_q.size();
    idx = 0;
    cut = 1'b0;
    readout_start_i = 1'b1;
    step_cycle();
    readout_start_i = 1'b0;
    if (n == 0) begin
      repeat (LAT + 4) begin
        compare_flag("out_valid_o", out_valid_o, 1'b0);
        step_cycle();
      end
    end else begin
      // first word lands one read latency after the first read
      repeat (LAT) begin
        compare_flag("out_valid_o", out_valid_o, 1'b0);
        step_cycle();
      end
      while (idx < n && !cut) begin
        compare_flag("out_valid_o", out_valid_o, 1'b1);
        got = out_data_o;
        compare_word(got, exp_q[idx], kind_q[idx], idx);
        compare_flag("out_last_o", out_last_o, idx == n - 1);
        idx++;
        if (idx == cut_at) begin
          readout_reset_i = 1'b1;
          cut = 1'b1;
        end
        step_cycle();
        readout_reset_i = 1'b0;
      end
      compare_flag("out_valid_o", out_valid_o, 1'b0);
    end
  endtask

  initial begin
    seed            = 32'd30;
    s_rate          = 8;
    t_rate          = 8;
    rst_i           = 1'b1;
    sample_valid_i  = '0;
    sample_data_i   = '0;
    tstamp_valid_i  = '0;
    tstamp_data_i   = '0;
    trigger_i       = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_arm_i       = 1'b0;
    cmd_start_i     = 1'b0;
    cmd_stop_i      = 1'b0;
    banking_mode_i  = 1'b0;
    capture_reset_i = 1'b0;
    readout_start_i = 1'b0;
    readout_reset_i = 1'b0;
    repeat (16) step_cycle();
    rst_i = 1'b0;

    // software start with a random stop, separate then joined banks
    for (int mode = 0; mode < 2; mode++) begin
      run_capture(1'(mode), 1'b0, rand_range(8, 40), 0);
      run_readout(0);
    end

    // hardware trigger after a random wait in the armed state
    run_capture(1'b0, 1'b1, rand_range(10, 30), rand_range(4, 12));
    run_readout(0);

    // joined banks filled by channel 0
    s_rate = 16;
    t_rate = 4;
    run_capture(1'b1, 1'b0, 4 * SD, 0);
    compare_depth("sample_depth_o[0]", sample_depth_o[0], 2 * SD);
    run_readout(0);

    // capture reset partway, then a fresh capture
    s_rate         = 8;
    t_rate         = 8;
    banking_mode_i = 1'b0;
    send_cmd(1'b1, 1'b1, 1'b0);
    repeat (12) step_cycle();
    capture_reset_i = 1'b1;
    step_cycle();
    capture_reset_i = 1'b0;
    run_capture(1'b0, 1'b0, rand_range(10, 30), 0);
    run_readout(0);

    // readout reset mid stream, then a full readout
    s_rate = 12;
    t_rate = 12;
    run_capture(1'b1, 1'b0, 30, 0);
    run_readout(5);
    run_readout(0);

    // samples only, timestamps only, then nothing at all
    s_rate = 8;
    t_rate = 0;
    run_capture(1'b0, 1'b0, rand_range(10, 30), 0);
    run_readout(0);
    s_rate = 0;
    t_rate = 8;
    run_capture(1'b1, 1'b0, rand_range(10, 30), 0);
    run_readout(0);
    t_rate = 0;
    run_capture(1'b0, 1'b0, 6, 0);
    run_readout(0);

    repeat (4) step_cycle();
    if (DUT.sva_chk.err_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      fail_run("an assertion in timetag_buffer_sva failed");
    end
  end

endmodule
